/* logic/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // core states the bridge reacts to
  typedef enum logic [5:0] {
    WAIT_FOR_START,
    READ_MEM_SIZE_1,
    READ_DST,
    READ_DST_P,
    READ_COND,
    READ_COND_P,
    READ_SRC1,
    READ_SRC1_P,
    READ_SRC0,
    READ_SRC0_P,
    START_READ_CMD,
    START_READ_CMD_P,
    WRITE_REG_IP,
    WRITE_DST,
    WRITE_DST_P,
    WRITE_SRC1,
    WRITE_SRC0,
    WRITE_COND,
    ALU_BEGIN,
    FINISH_BEGIN,
    FINISH_END,
    BREAK_THREAD_SAVE_IP_AND_WAIT,
    BREAK_THREAD_EXIT_AND_WAIT,
    AUX_PRE_FINISH_BEGIN,
    IDLE
  } core_state_t;

  // messages passed around the ring
  typedef enum logic [3:0] {
    MSG_NONE,
    MSG_RESET,
    MSG_START,
    MSG_END,
    MSG_BREAK_THREAD
  } cpu_msg_t;

  // ring index, whole word or active bit plus ordinal
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic        active;
      logic [30:0] ordinal;
    } fields;
  } cpu_index_u;

  // offered index compared with own index
  typedef enum logic [1:0] {
    REL_NONE   = 2'b00,
    REL_LOWER  = 2'b01,
    REL_HIGHER = 2'b10,
    REL_EQUAL  = 2'b11
  } ind_rel_t;

  typedef enum logic [1:0] {
    CLASS_READ,
    CLASS_WRITE,
    CLASS_OTHER
  } state_class_t;

  // read and write states open the outside bus
  function automatic state_class_t state_class(input core_state_t s);
    state_class_t c;
    c = CLASS_OTHER;
    if (s >= READ_MEM_SIZE_1 && s <= START_READ_CMD_P) begin
      c = CLASS_READ;
    end else if (s >= WRITE_REG_IP && s <= WRITE_COND) begin
      c = CLASS_WRITE;
    end
    return c;
  endfunction

endpackage

`default_nettype wire

/* logic/bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_top import bridge_pkg::*; #(
  parameter int HEADER_SPACE  = 4,
  parameter int NO_DATA_LIMIT = 8
) (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  core_state_t state,
  input  logic        read_q,
  input  logic        write_q,
  input  logic        bus_busy_in,
  input  logic        ext_next_cpu_q,
  input  cpu_index_u  ext_cpu_index,
  input  cpu_msg_t    ext_cpu_msg_in,
  input  addr_t       addr_in,
  input  data_t       data_in,
  input  logic        no_data_new,
  input  logic        no_data_tick,
  output logic        rst,
  output logic        ext_rst_e,
  output logic        bus_busy_out,
  output logic        disp_online,
  output logic        ext_dispatcher_q,
  output logic        ext_next_cpu_e,
  output ind_rel_t    cpu_ind_rel,
  output cpu_msg_t    ext_cpu_msg,
  output logic        next_state,
  output logic        ext_read_q,
  output logic        ext_write_q,
  output addr_t       base_addr,
  output data_t       base_addr_data,
  output addr_t       addr_out,
  output data_t       data_out,
  output logic        thread_escape,
  output logic        no_data_exit_and_wait_begin
);

  // sequencer to token logic
  logic running;
  logic index_load;
  logic reset_msg;
  logic dispatcher_req;
  logic clear_idle;
  logic restart;
  // token logic and thread context
  logic start_grant;
  logic escape_hit;

  reset_sequencer u_reset_sequencer (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .restart        (restart),
    .running        (running),
    .index_load     (index_load),
    .reset_msg      (reset_msg),
    .rst            (rst),
    .ext_rst_e      (ext_rst_e),
    .bus_busy_out   (bus_busy_out),
    .dispatcher_req (dispatcher_req),
    .clear_idle     (clear_idle)
  );

  token_controller u_token_controller (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .running          (running),
    .index_load       (index_load),
    .reset_msg        (reset_msg),
    .dispatcher_req   (dispatcher_req),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_cpu_index    (ext_cpu_index),
    .idle_exit        (no_data_exit_and_wait_begin),
    .escape_hit       (escape_hit),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .disp_online      (disp_online),
    .ext_dispatcher_q (ext_dispatcher_q),
    .cpu_ind_rel      (cpu_ind_rel),
    .cpu_msg          (ext_cpu_msg),
    .next_state       (next_state),
    .start_grant      (start_grant),
    .restart          (restart),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

  thread_context #(
    .HEADER_SPACE (HEADER_SPACE)
  ) u_thread_context (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .start_grant    (start_grant),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .cpu_msg        (ext_cpu_msg),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .cpu_ind_rel    (cpu_ind_rel),
    .running        (running),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .addr_out       (addr_out),
    .data_out       (data_out),
    .escape_hit     (escape_hit),
    .thread_escape  (thread_escape)
  );

  no_data_watchdog #(
    .NO_DATA_LIMIT (NO_DATA_LIMIT)
  ) u_no_data_watchdog (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .clear_idle   (clear_idle),
    .no_data_new  (no_data_new),
    .no_data_tick (no_data_tick),
    .exit_wait    (no_data_exit_and_wait_begin)
  );

endmodule

`default_nettype wire

/* logic/no_data_watchdog.sv */
`timescale 1ns/1ps
`default_nettype none

module no_data_watchdog #(
  parameter int NO_DATA_LIMIT = 8
) (
  input  logic clk,
  input  logic ext_rst_b,
  input  logic clear_idle,
  input  logic no_data_new,
  input  logic no_data_tick,
  output logic exit_wait
);

  localparam int CNT_W = $clog2(NO_DATA_LIMIT + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(NO_DATA_LIMIT);

  logic [CNT_W-1:0] idle_cnt;

  always_ff @(posedge clk) begin
    if (ext_rst_b || clear_idle || no_data_new) begin
      idle_cnt  <= '0;
      exit_wait <= 1'b0;
    end else if (no_data_tick) begin
      // counter saturates, flag sticks until new data
      if (idle_cnt >= LIMIT) begin
        exit_wait <= 1'b1;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer import bridge_pkg::*; (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  core_state_t state,
  input  logic        restart,
  output logic        running,
  output logic        index_load,
  output logic        reset_msg,
  output logic        rst,
  output logic        ext_rst_e,
  output logic        bus_busy_out,
  output logic        dispatcher_req,
  output logic        clear_idle
);

  // join steps, one per clock
  localparam logic [2:0] STEP_INIT     = 3'd1;
  localparam logic [2:0] STEP_CHECK    = 3'd2;
  localparam logic [2:0] STEP_ANNOUNCE = 3'd3;
  localparam logic [2:0] STEP_RESET    = 3'd4;
  localparam logic [2:0] STEP_RELEASE  = 3'd5;
  localparam logic [2:0] STEP_SETTLE   = 3'd6;
  localparam logic [2:0] STEP_RUN      = 3'd7;

  logic [2:0] step;

  // own index is taken at the end of the check step
  // unless the core came back from finish-end
  assign index_load = (step == STEP_CHECK) && (state != FINISH_END);

  // dispatcher request from the core reset cycle onward
  assign dispatcher_req = (step >= STEP_RELEASE);
  assign running        = (step == STEP_RUN);
  assign clear_idle     = (step != STEP_RUN);

  always_ff @(posedge clk) begin
    if (ext_rst_b || restart) begin
      step         <= STEP_INIT;
      reset_msg    <= 1'b0;
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
    end else begin
      // pulses by default
      reset_msg    <= 1'b0;
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
      case (step)
        STEP_INIT: step <= STEP_CHECK;
        STEP_CHECK: begin
          // rejoin after finish-end, no announce
          if (state == FINISH_END) begin
            step <= STEP_RESET;
          end else begin
            step      <= STEP_ANNOUNCE;
            reset_msg <= 1'b1;
          end
        end
        STEP_ANNOUNCE: step <= STEP_RESET;
        STEP_RESET: begin
          rst          <= 1'b1;
          bus_busy_out <= 1'b1;
          // ring is not told about a plain rejoin
          ext_rst_e    <= (state != FINISH_END);
          step         <= STEP_RELEASE;
        end
        STEP_RELEASE: step <= STEP_SETTLE;
        default: step <= STEP_RUN;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/thread_context.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_context import bridge_pkg::*; #(
  parameter int HEADER_SPACE = 4
) (
  input  logic     clk,
  input  logic     ext_rst_b,
  input  logic     start_grant,
  input  addr_t    addr_in,
  input  data_t    data_in,
  input  cpu_msg_t cpu_msg,
  input  cpu_msg_t ext_cpu_msg_in,
  input  ind_rel_t cpu_ind_rel,
  input  logic     running,
  output addr_t    base_addr,
  output data_t    base_addr_data,
  output addr_t    addr_out,
  output data_t    data_out,
  output logic     escape_hit,
  output logic     thread_escape
);

  localparam addr_t HDR_ADDR = addr_t'(HEADER_SPACE);
  localparam data_t HDR_DATA = data_t'(HEADER_SPACE);

  addr_t thread_addr;
  data_t thread_data;

  // thread start, header excluded
  assign thread_addr = base_addr - HDR_ADDR;
  assign thread_data = base_addr_data - HDR_DATA;

  // shown to the ring only with our own break
  assign addr_out = (cpu_msg == MSG_BREAK_THREAD) ? thread_addr : '0;
  assign data_out = (cpu_msg == MSG_BREAK_THREAD) ? thread_data : '0;

  // a higher cpu breaks the thread we run
  assign escape_hit = (ext_cpu_msg_in == MSG_BREAK_THREAD) &&
                      (addr_in == thread_addr) &&
                      (data_in == thread_data) &&
                      (cpu_ind_rel == REL_HIGHER);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      base_addr      <= '0;
      base_addr_data <= '0;
      thread_escape  <= 1'b0;
    end else begin
      thread_escape <= running && escape_hit;
      if (start_grant) begin
        base_addr <= addr_in + HDR_ADDR;
        // data base falls back to the code base
        base_addr_data <= (data_in == '0) ? data_t'(addr_in) + HDR_DATA : data_in + HDR_DATA;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/token_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module token_controller import bridge_pkg::*; (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  core_state_t state,
  input  logic        running,
  input  logic        index_load,
  input  logic        reset_msg,
  input  logic        dispatcher_req,
  input  logic        read_q,
  input  logic        write_q,
  input  logic        bus_busy_in,
  input  logic        ext_next_cpu_q,
  input  cpu_index_u  ext_cpu_index,
  input  logic        idle_exit,
  input  logic        escape_hit,
  output logic        ext_next_cpu_e,
  output logic        disp_online,
  output logic        ext_dispatcher_q,
  output ind_rel_t    cpu_ind_rel,
  output cpu_msg_t    cpu_msg,
  output logic        next_state,
  output logic        start_grant,
  output logic        restart,
  output logic        ext_read_q,
  output logic        ext_write_q
);

  cpu_index_u   own_index;
  state_class_t cls;
  logic         grant;
  logic         next_cpu_e_stim;

  assign cls = state_class(state);

  // token offered to us and the ring is not busy
  assign grant = running && !bus_busy_in && ext_next_cpu_q &&
                 (ext_cpu_index.raw == own_index.raw);
  assign start_grant = grant && (state == WAIT_FOR_START);

  // core finished, go through the join steps again
  assign restart = running && !bus_busy_in && (state == FINISH_END);

  // pass the token once the bus access is issued
  assign next_cpu_e_stim = (read_q || write_q) && disp_online && !ext_next_cpu_e;

  // bus requests only while online and in a matching state
  assign ext_read_q  = (cls == CLASS_READ && disp_online) ? read_q : 1'b0;
  assign ext_write_q = (cls == CLASS_WRITE && disp_online) ? write_q : 1'b0;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index.raw <= '0;
    end else if (index_load) begin
      own_index <= ext_cpu_index;
    end
  end

  // relation of offered index, ordinals first
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel <= REL_NONE;
    end else if (ext_next_cpu_q) begin
      if (ext_cpu_index.fields.ordinal < own_index.fields.ordinal) begin
        cpu_ind_rel <= REL_LOWER;
      end else if (ext_cpu_index.fields.ordinal > own_index.fields.ordinal) begin
        cpu_ind_rel <= REL_HIGHER;
      end else if (ext_cpu_index.raw == own_index.raw) begin
        cpu_ind_rel <= REL_EQUAL;
      end
    end else if (ext_next_cpu_e) begin
      cpu_ind_rel <= REL_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_msg          <= MSG_NONE;
      ext_next_cpu_e   <= 1'b0;
      disp_online      <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      next_state       <= 1'b0;
    end else if (!running) begin
      // join in progress, only the reset message goes out
      cpu_msg          <= reset_msg ? MSG_RESET : MSG_NONE;
      ext_dispatcher_q <= dispatcher_req;
      ext_next_cpu_e   <= 1'b0;
      disp_online      <= 1'b0;
      next_state       <= 1'b0;
    end else begin
      next_state <= escape_hit;
      // busy ring holds the token logic
      if (!bus_busy_in) begin
        cpu_msg        <= MSG_NONE;
        ext_next_cpu_e <= next_cpu_e_stim;
        if (ext_next_cpu_e) begin
          disp_online <= 1'b0;
        end
        if (grant) begin
          disp_online <= 1'b1;
          case (state)
            WAIT_FOR_START: begin
              cpu_msg        <= MSG_START;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
            end
            FINISH_BEGIN: begin
              cpu_msg          <= MSG_END;
              ext_dispatcher_q <= 1'b1;
              ext_next_cpu_e   <= 1'b1;
              next_state       <= 1'b1;
            end
            BREAK_THREAD_SAVE_IP_AND_WAIT, BREAK_THREAD_EXIT_AND_WAIT: begin
              cpu_msg          <= MSG_BREAK_THREAD;
              ext_dispatcher_q <= 1'b1;
              ext_next_cpu_e   <= 1'b1;
              next_state       <= 1'b1;
            end
            AUX_PRE_FINISH_BEGIN: begin
              ext_dispatcher_q <= 1'b1;
              ext_next_cpu_e   <= 1'b1;
              next_state       <= 1'b1;
            end
            default: begin
              if (cls != CLASS_OTHER) begin
                ext_dispatcher_q <= 1'b1;
              end
            end
          endcase
        end else begin
          case (state)
            FINISH_BEGIN: ext_dispatcher_q <= 1'b1;
            WAIT_FOR_START, IDLE: ext_dispatcher_q <= 1'b0;
            default: begin
              if (cls != CLASS_OTHER) begin
                ext_dispatcher_q <= 1'b1;
              end
              // no data for too long, leave the read
              if (cls == CLASS_READ && idle_exit) begin
                next_state <= 1'b1;
              end
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* project.f */
logic/bridge_pkg.sv
logic/reset_sequencer.sv
logic/token_controller.sv
logic/thread_context.sv
logic/no_data_watchdog.sv
logic/bridge_top.sv
tb/bridge_tb.sv

/* tb/bridge_cases.txt */
# kind state own offered addr data rd wr exp_msg exp_rel exp_addr exp_data exp_flag aux
# kind 0 join 1 start 2 relation 3 gating 4 break 5 idle, rd wr in binary, rest in hex
0 00 80000005 00000000 00000000 00000000 0 0 1 0 00000000 00000000 1 0
0 14 80000005 00000000 00000000 00000000 0 0 0 0 00000000 00000000 0 0
1 00 80000005 80000005 00001000 00002000 0 0 2 3 00001004 00002004 1 0
1 00 80000005 80000005 00003000 00000000 0 0 2 3 00003004 00003004 1 0
1 00 00000007 00000007 00ff0010 00000100 0 0 2 3 00ff0014 00000104 1 0
2 18 80000005 80000003 00000000 00000000 0 0 0 1 00000000 00000000 0 0
2 18 80000005 80000009 00000000 00000000 0 0 0 2 00000000 00000000 0 0
2 18 80000005 80000005 00000000 00000000 0 0 0 3 00000000 00000000 0 0
2 18 80000005 00000002 00000000 00000000 0 0 0 1 00000000 00000000 0 0
2 18 80000005 00000040 00000000 00000000 0 0 0 2 00000000 00000000 0 0
3 02 80000005 80000005 00000000 00000000 1 0 0 0 00000000 00000000 2 0
3 02 80000005 80000005 00000000 00000000 0 1 0 0 00000000 00000000 0 0
3 0d 80000005 80000005 00000000 00000000 0 1 0 0 00000000 00000000 1 0
3 0d 80000005 80000005 00000000 00000000 1 0 0 0 00000000 00000000 0 0
3 18 80000005 80000005 00000000 00000000 1 1 0 0 00000000 00000000 0 0
3 0a 80000005 80000005 00000000 00000000 1 1 0 0 00000000 00000000 2 0
3 11 80000005 80000005 00000000 00000000 1 1 0 0 00000000 00000000 1 0
4 15 80000005 80000005 00001000 00002000 0 0 4 0 00001000 00002000 1 00001000
4 16 80000005 80000005 00001000 00002000 0 0 4 0 00001000 00002000 0 00001040
4 15 80000005 80000005 00004400 00000000 0 0 4 0 00004400 00004400 1 00004400
5 02 80000005 80000005 00000000 00000000 0 0 0 0 00000000 00000000 1 9
5 02 80000005 80000005 00000000 00000000 0 0 0 0 00000000 00000000 0 8
5 06 80000005 80000005 00000000 00000000 0 0 0 0 00000000 00000000 1 c

/* tb/bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_tb import bridge_pkg::*; ();

  localparam int MAX_CASES = 64;

  logic clk;
  logic ext_rst_b;
  core_state_t state;
  logic read_q;
  logic write_q;
  logic bus_busy_in;
  logic ext_next_cpu_q;
  cpu_index_u ext_cpu_index;
  cpu_msg_t ext_cpu_msg_in;
  addr_t addr_in;
  data_t data_in;
  logic no_data_new;
  logic no_data_tick;
  logic rst;
  logic ext_rst_e;
  logic bus_busy_out;
  logic disp_online;
  logic ext_dispatcher_q;
  logic ext_next_cpu_e;
  ind_rel_t cpu_ind_rel;
  cpu_msg_t ext_cpu_msg;
  logic next_state;
  logic ext_read_q;
  logic ext_write_q;
  addr_t base_addr;
  data_t base_addr_data;
  addr_t addr_out;
  data_t data_out;
  logic thread_escape;
  logic no_data_exit_and_wait_begin;

  // case table, one entry per line of the case file
  logic [31:0] c_kind [MAX_CASES];
  logic [31:0] c_state [MAX_CASES];
  logic [31:0] c_own [MAX_CASES];
  logic [31:0] c_offer [MAX_CASES];
  logic [31:0] c_addr [MAX_CASES];
  logic [31:0] c_data [MAX_CASES];
  logic [31:0] c_rd [MAX_CASES];
  logic [31:0] c_wr [MAX_CASES];
  logic [31:0] c_msg [MAX_CASES];
  logic [31:0] c_rel [MAX_CASES];
  logic [31:0] c_eaddr [MAX_CASES];
  logic [31:0] c_edata [MAX_CASES];
  logic [31:0] c_flag [MAX_CASES];
  logic [31:0] c_aux [MAX_CASES];
  int n_cases;
  int errors;
  int checks;
  logic loaded;

  bridge_top #(
    .HEADER_SPACE  (4),
    .NO_DATA_LIMIT (8)
  ) u_dut (
    .clk                         (clk),
    .ext_rst_b                   (ext_rst_b),
    .state                       (state),
    .read_q                      (read_q),
    .write_q                     (write_q),
    .bus_busy_in                 (bus_busy_in),
    .ext_next_cpu_q              (ext_next_cpu_q),
    .ext_cpu_index               (ext_cpu_index),
    .ext_cpu_msg_in              (ext_cpu_msg_in),
    .addr_in                     (addr_in),
    .data_in                     (data_in),
    .no_data_new                 (no_data_new),
    .no_data_tick                (no_data_tick),
    .rst                         (rst),
    .ext_rst_e                   (ext_rst_e),
    .bus_busy_out                (bus_busy_out),
    .disp_online                 (disp_online),
    .ext_dispatcher_q            (ext_dispatcher_q),
    .ext_next_cpu_e              (ext_next_cpu_e),
    .cpu_ind_rel                 (cpu_ind_rel),
    .ext_cpu_msg                 (ext_cpu_msg),
    .next_state                  (next_state),
    .ext_read_q                  (ext_read_q),
    .ext_write_q                 (ext_write_q),
    .base_addr                   (base_addr),
    .base_addr_data              (base_addr_data),
    .addr_out                    (addr_out),
    .data_out                    (data_out),
    .thread_escape               (thread_escape),
    .no_data_exit_and_wait_begin (no_data_exit_and_wait_begin)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit scales with the number of cases
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = (longint'(n_cases) * 40 + 200) * 100;
    #(limit_ns);
    $display("simulation timed out after %0d ns, test did not complete", limit_ns);
    $display("** FAIL **");
    $finish;
  end

  task automatic check_msg(input cpu_msg_t got, input cpu_msg_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_rel(input ind_rel_t got, input ind_rel_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // token offer held for one clock, results visible on return
  task automatic offer_token(input logic [31:0] idx);
    ext_next_cpu_q = 1'b1;
    ext_cpu_index = idx;
    @(negedge clk);
    ext_next_cpu_q = 1'b0;
  endtask

  task automatic wait_token_free();
    int n;
    n = 0;
    while ((disp_online || ext_next_cpu_e) && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (disp_online || ext_next_cpu_e) begin
      errors++;
      $display("dispatcher never went offline after the token was passed");
    end
  endtask

  // reset, then the join steps up to the dispatcher request
  task automatic join_ring(input core_state_t js, input logic [31:0] own,
                           input cpu_msg_t exp_msg, input logic exp_ext);
    int n;
    int msg_cnt;
    int rst_cnt;
    int msg_at;
    int rst_at;
    logic ext_seen;
    msg_cnt = 0;
    rst_cnt = 0;
    msg_at = -10;
    rst_at = -10;
    ext_seen = 1'b0;
    n = 0;
    ext_rst_b = 1'b1;
    state = js;
    ext_cpu_index = own;
    repeat (5) @(negedge clk);
    ext_rst_b = 1'b0;
    @(negedge clk);
    while (!ext_dispatcher_q && n < 20) begin
      if (ext_cpu_msg == MSG_RESET) begin
        msg_cnt++;
        msg_at = n;
        check_bit(rst_cnt == 0, 1'b1, "reset message before core reset");
      end
      if (rst) begin
        rst_cnt++;
        rst_at = n;
        check_bit(bus_busy_out, 1'b1, "bus_busy_out with rst");
        ext_seen = ext_rst_e;
      end else begin
        // ring reset and bus busy only travel with the core reset
        check_bit(ext_rst_e, 1'b0, "ext_rst_e without rst");
        check_bit(bus_busy_out, 1'b0, "bus_busy_out without rst");
      end
      @(negedge clk);
      n++;
    end
    if (!ext_dispatcher_q) begin
      errors++;
      $display("dispatcher request never came during the join");
    end
    check_bit(msg_cnt == ((exp_msg == MSG_RESET) ? 1 : 0), 1'b1, "reset message cycles");
    check_bit(rst_cnt == 1, 1'b1, "one core reset cycle");
    check_bit(ext_seen, exp_ext, "ext_rst_e during join");
    // each join step follows the one before directly
    if (exp_msg == MSG_RESET) begin
      check_bit(rst_at == msg_at + 1, 1'b1, "core reset follows reset message");
    end
    check_bit(n == rst_at + 1, 1'b1, "dispatcher request follows core reset");
    // running starts on the next edge
    @(negedge clk);
  endtask

  task automatic run_case(input int i);
    core_state_t st;
    st = core_state_t'(c_state[i][5:0]);
    if (c_kind[i] == 0) begin
      join_ring(st, c_own[i], cpu_msg_t'(c_msg[i][3:0]), c_flag[i][0]);
      return;
    end
    join_ring(IDLE, c_own[i], MSG_RESET, 1'b1);
    addr_in = c_addr[i];
    data_in = c_data[i];
    case (c_kind[i])
      1: begin
        state = WAIT_FOR_START;
        offer_token(c_offer[i]);
        check_msg(ext_cpu_msg, cpu_msg_t'(c_msg[i][3:0]), "start message");
        check_bit(ext_next_cpu_e, 1'b1, "token passed on start");
        check_bit(next_state, c_flag[i][0], "next_state on start");
        check_bit(disp_online, 1'b1, "disp_online on start");
        check_addr(base_addr, c_eaddr[i], "base_addr");
        check_data(base_addr_data, c_edata[i], "base_addr_data");
        check_rel(cpu_ind_rel, ind_rel_t'(c_rel[i][1:0]), "relation on grant");
        @(negedge clk);
        check_bit(next_state, 1'b0, "next_state after one cycle");
        check_rel(cpu_ind_rel, REL_NONE, "relation after token passed");
      end
      2: begin
        state = st;
        offer_token(c_offer[i]);
        check_rel(cpu_ind_rel, ind_rel_t'(c_rel[i][1:0]), "offered index relation");
        state = WAIT_FOR_START;
        offer_token(c_own[i]);
        check_bit(ext_next_cpu_e, 1'b1, "token passed");
        @(negedge clk);
        check_rel(cpu_ind_rel, REL_NONE, "relation cleared");
      end
      3: begin
        state = st;
        read_q = c_rd[i][0];
        write_q = c_wr[i][0];
        @(negedge clk);
        check_bit(ext_read_q, 1'b0, "ext_read_q while offline");
        check_bit(ext_write_q, 1'b0, "ext_write_q while offline");
        offer_token(c_own[i]);
        check_bit(disp_online, 1'b1, "disp_online after grant");
        check_bit(ext_read_q, c_flag[i][1], "ext_read_q while online");
        check_bit(ext_write_q, c_flag[i][0], "ext_write_q while online");
        wait_token_free();
        check_bit(ext_read_q, 1'b0, "ext_read_q after release");
        check_bit(ext_write_q, 1'b0, "ext_write_q after release");
        read_q = 1'b0;
        write_q = 1'b0;
      end
      4: begin
        // thread start sets the bases first
        state = WAIT_FOR_START;
        offer_token(c_own[i]);
        state = IDLE;
        wait_token_free();
        state = st;
        offer_token(c_own[i]);
        state = IDLE;
        check_msg(ext_cpu_msg, cpu_msg_t'(c_msg[i][3:0]), "break message");
        check_addr(addr_out, c_eaddr[i], "addr_out on break");
        check_data(data_out, c_edata[i], "data_out on break");
        check_bit(next_state, 1'b1, "next_state on break");
        wait_token_free();
        // a higher cpu takes part in the break
        offer_token(c_own[i] + 32'h10);
        check_rel(cpu_ind_rel, REL_HIGHER, "relation of remote cpu");
        ext_cpu_msg_in = MSG_BREAK_THREAD;
        addr_in = c_aux[i];
        data_in = c_edata[i];
        @(negedge clk);
        ext_cpu_msg_in = MSG_NONE;
        check_bit(thread_escape, c_flag[i][0], "thread_escape");
        check_bit(next_state, c_flag[i][0], "next_state on escape");
      end
      default: begin
        state = st;
        no_data_new = 1'b1;
        @(negedge clk);
        no_data_new = 1'b0;
        no_data_tick = 1'b1;
        repeat (c_aux[i]) @(negedge clk);
        no_data_tick = 1'b0;
        check_bit(no_data_exit_and_wait_begin, c_flag[i][0], "exit-and-wait flag");
        @(negedge clk);
        check_bit(next_state, c_flag[i][0], "next_state on idle exit");
        no_data_new = 1'b1;
        @(negedge clk);
        no_data_new = 1'b0;
        check_bit(no_data_exit_and_wait_begin, 1'b0, "exit flag after new data");
      end
    endcase
  endtask

  initial begin
    int fd;
    int got;
    string line;
    errors = 0;
    checks = 0;
    n_cases = 0;
    loaded = 1'b0;
    ext_rst_b = 1'b1;
    state = IDLE;
    read_q = 1'b0;
    write_q = 1'b0;
    bus_busy_in = 1'b0;
    ext_next_cpu_q = 1'b0;
    ext_cpu_index = '0;
    ext_cpu_msg_in = MSG_NONE;
    addr_in = '0;
    data_in = '0;
    no_data_new = 1'b0;
    no_data_tick = 1'b0;
    fd = $fopen("tb/bridge_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file tb/bridge_cases.txt");
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        line = "";
        void'($fgets(line, fd));
        got = $sscanf(line, "%h %h %h %h %h %h %b %b %h %h %h %h %h %h",
                      c_kind[n_cases], c_state[n_cases], c_own[n_cases], c_offer[n_cases],
                      c_addr[n_cases], c_data[n_cases], c_rd[n_cases], c_wr[n_cases],
                      c_msg[n_cases], c_rel[n_cases], c_eaddr[n_cases], c_edata[n_cases],
                      c_flag[n_cases], c_aux[n_cases]);
        // header and blank lines do not parse
        if (got == 14 && line[0] != "#") begin
          n_cases++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("cases %0d, checks %0d, errors %0d", n_cases, checks, errors);
    if (errors == 0 && n_cases > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
